// File: sources.f
verilog/rvPkg.sv
verilog/execIf.sv
verilog/alu.sv
verilog/branchUnit.sv
verilog/execCommit.sv
verilog/executeStage.sv
verif/execChecker.sv
verif/tbExecute.sv

// File: Bender.yml
package:
  name: execute_stage

sources:
  - verilog/rvPkg.sv
  - verilog/execIf.sv
  - verilog/alu.sv
  - verilog/branchUnit.sv
  - verilog/execCommit.sv
  - verilog/executeStage.sv
  - target: simulation
    files:
      - verif/execChecker.sv
      - verif/tbExecute.sv

// File: verif/tbExecute.sv
`timescale 1ns/1ps

module tbExecute;

  localparam int RESET_CYCLES = 16;
  localparam int TEST_CYCLES  = 700;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + TEST_CYCLES + 50;

  logic                        clk, arstN, inValid;
  logic [2:0]                  testId;
  logic [6:0]                  opcode, funct7;
  logic [2:0]                  funct3;
  logic [rvPkg::WORD_SIZE-1:0] pc, op1, op2, imm;
  logic                        outValid, branchTaken;
  logic [rvPkg::WORD_SIZE-1:0] result, newPc;
  int                          errorCount, checkCount, cycleCount;
  integer                      seed;

  executeStage uut (
    .clk, .arstN, .inValid, .opcode, .funct7, .funct3, .pc, .op1, .op2, .imm,
    .outValid, .result, .newPc, .branchTaken
  );

  execChecker execCheck (
    .clk, .arstN, .testId, .inValid, .opcode, .funct7, .funct3, .pc, .op1, .op2, .imm,
    .outValid, .result, .newPc, .branchTaken, .errorCount, .checkCount
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==============================
  // Stimulus helpers
  // ==============================

  task automatic driveSlot(input logic valid, input logic [6:0] opc, input logic [6:0] f7,
      input logic [2:0] f3, input logic [31:0] pcV, a, b, im);
    @(posedge clk);
    #1;
    inValid = valid;
    opcode  = opc;
    funct7  = f7;
    funct3  = f3;
    pc      = pcV;
    op1     = a;
    op2     = b;
    imm     = im;
  endtask

  function automatic logic [6:0] pickOpcode(input int idx);
    case (idx)
      0: return rvPkg::OPCODE_ALU;
      1: return rvPkg::OPCODE_ALU_IMM;
      2: return rvPkg::OPCODE_AUIPC;
      3: return rvPkg::OPCODE_BRANCH;
      4: return rvPkg::OPCODE_JUMP;
      5: return rvPkg::OPCODE_LOAD;
      default: return rvPkg::OPCODE_STORE;
    endcase
  endfunction

  task automatic idleCycles(input int count);
    repeat (count) driveSlot(1'b0, 7'd0, 7'd0, 3'd0, '0, '0, '0, '0);
  endtask

  task automatic issueAluOps(input int count);
    int         kind;
    logic [6:0] f7;
    logic [2:0] f3;
    repeat (count) begin
      kind = $unsigned($random(seed)) % 7;
      f7   = rvPkg::ADD_OR_AND_FUNCT7;
      f3   = $random(seed);
      case (kind)
        0: f3 = rvPkg::ADD_FUNCT3;
        1: f7 = rvPkg::SUB_FUNCT7;
        2: f7 = rvPkg::MUL_FUNCT7;
        3: f3 = rvPkg::OR_FUNCT3;
        4: f3 = rvPkg::AND_FUNCT3;
        5: f3 = 3'd1 + $unsigned($random(seed)) % 5; // No operation under funct7 zero
        default: f7 = 7'h40 | $random(seed); // Funct7 outside the defined set
      endcase
      driveSlot(1'b1, rvPkg::OPCODE_ALU, f7, f3, $random(seed), $random(seed),
        $random(seed), $random(seed));
    end
  endtask

  task automatic addressAndImmOps(input int count);
    int         kind;
    logic [6:0] opc;
    logic [2:0] f3;
    repeat (count) begin
      kind = $unsigned($random(seed)) % 4;
      f3   = $random(seed);
      case (kind)
        0: opc = rvPkg::OPCODE_LOAD;
        1: opc = rvPkg::OPCODE_STORE;
        2: opc = rvPkg::OPCODE_ALU_IMM;
        default: opc = rvPkg::OPCODE_AUIPC;
      endcase
      if (kind == 2) f3 = rvPkg::ADDI_FUNCT3;
      driveSlot(1'b1, opc, $random(seed), f3, $random(seed), $random(seed),
        $random(seed), $random(seed));
    end
  endtask

  task automatic branchMix(input int count);
    int          kind;
    logic [2:0]  f3;
    logic [31:0] a, b;
    repeat (count) begin
      kind = $unsigned($random(seed)) % 5;
      a    = $random(seed);
      b    = $random(seed);
      if ($unsigned($random(seed)) % 4 == 0) b = a; // Equal operands
      case (kind)
        0: f3 = rvPkg::BEQ_FUNCT3;
        1: f3 = rvPkg::BNE_FUNCT3;
        2: f3 = rvPkg::BLT_FUNCT3;
        default: f3 = rvPkg::BGE_FUNCT3;
      endcase
      driveSlot(1'b1, (kind == 4) ? rvPkg::OPCODE_JUMP : rvPkg::OPCODE_BRANCH,
        $random(seed), f3, $random(seed), a, b, $random(seed));
    end
  endtask

  task automatic bubbleStream(input int count);
    logic       valid;
    logic [6:0] f7;
    repeat (count) begin
      valid = ($unsigned($random(seed)) % 3) != 0; // About a third of the slots are empty
      case ($unsigned($random(seed)) % 4)
        0: f7 = rvPkg::ADD_OR_AND_FUNCT7;
        1: f7 = rvPkg::SUB_FUNCT7;
        2: f7 = rvPkg::MUL_FUNCT7;
        default: f7 = $random(seed);
      endcase
      driveSlot(valid, pickOpcode($unsigned($random(seed)) % 7), f7, $random(seed),
        $random(seed), $random(seed), $random(seed), $random(seed));
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================

  initial begin : stimulus
    seed    = 43515;
    arstN   = 1'b1;
    testId  = 3'd0;
    inValid = 1'b0;
    opcode  = '0;
    funct7  = '0;
    funct3  = '0;
    pc      = '0;
    op1     = '0;
    op2     = '0;
    imm     = '0;
    #1;
    arstN = 1'b0; // Falling edge clears the output flops before the first clock
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arstN = 1'b1;
    idleCycles(4);
    testId = 3'd1;
    issueAluOps(200);
    testId = 3'd2;
    addressAndImmOps(150);
    testId = 3'd3;
    branchMix(200);
    testId = 3'd4;
    bubbleStream(150);
    idleCycles(3); // Flush the last slot through the compare
    $display("Errors: %0d, checks: %0d", errorCount, checkCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < CYCLE_LIMIT) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Errors: %0d, checks: %0d", errorCount + 1, checkCount);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: verif/execChecker.sv
`timescale 1ns/1ps

module execChecker (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic [2:0]                  testId,
  input  logic                        inValid,
  input  logic [6:0]                  opcode,
  input  logic [6:0]                  funct7,
  input  logic [2:0]                  funct3,
  input  logic [rvPkg::WORD_SIZE-1:0] pc, op1, op2, imm,
  input  logic                        outValid,
  input  logic [rvPkg::WORD_SIZE-1:0] result, newPc,
  input  logic                        branchTaken,
  output int                          errorCount,
  output int                          checkCount
);

  logic        havePrev;
  logic        prevValid;
  logic [2:0]  prevTest;
  logic [64:0] prevExpect; // Packed as result, newPc, taken

  // ==============================
  // Reference model
  // ==============================

  function automatic logic [64:0] expectExec(input logic [6:0] opc, input logic [6:0] f7,
      input logic [2:0] f3, input logic [31:0] pcV, a, b, im);
    logic [63:0] prod;
    logic [31:0] res;
    logic        taken;
    logic        plain;
    prod  = {32'b0, a} * {32'b0, b};
    plain = (f7 == rvPkg::ADD_OR_AND_FUNCT7);
    res   = '0;
    taken = 1'b0;
    case (opc)
      rvPkg::OPCODE_ALU: begin
        if (f7 == rvPkg::SUB_FUNCT7) res = a - b;
        else if (f7 == rvPkg::MUL_FUNCT7) res = prod[31:0]; // Low word only
        else if (plain && f3 == rvPkg::ADD_FUNCT3) res = a + b;
        else if (plain && f3 == rvPkg::OR_FUNCT3) res = a | b;
        else if (plain && f3 == rvPkg::AND_FUNCT3) res = a & b;
      end
      rvPkg::OPCODE_ALU_IMM: if (f3 == rvPkg::ADDI_FUNCT3) res = a + im;
      rvPkg::OPCODE_LOAD, rvPkg::OPCODE_STORE: res = a + im;
      rvPkg::OPCODE_AUIPC: res = pcV + im;
      rvPkg::OPCODE_BRANCH: begin
        res = a - b;
        case (f3)
          rvPkg::BEQ_FUNCT3: taken = (a == b);
          rvPkg::BNE_FUNCT3: taken = (a != b);
          rvPkg::BLT_FUNCT3: taken = (a < b); // Unsigned operands
          rvPkg::BGE_FUNCT3: taken = (a >= b);
          default: taken = 1'b0;
        endcase
      end
      rvPkg::OPCODE_JUMP: taken = 1'b1; // No link value, so the result stays zero
      default: res = '0;
    endcase
    return {res, pcV + im, taken};
  endfunction

  function automatic string testName(input logic [2:0] id);
    case (id)
      3'd0: return "reset";
      3'd1: return "aluOps";
      3'd2: return "addressAndImm";
      3'd3: return "branches";
      3'd4: return "bubbles";
      default: return "unknown";
    endcase
  endfunction

  task automatic compareField(input string name, input string field,
      input logic [31:0] expected, input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAIL %s %s: expected %h, actual %h", name, field, expected, actual);
    end
  endtask

  // ==============================
  // Compare one cycle later
  // ==============================

  initial begin
    errorCount = 0;
    checkCount = 0;
    havePrev   = 1'b0;
  end

  always @(posedge clk) begin : compareStep
    logic  expValid;
    string name;
    if (!arstN) begin
      compareField("reset", "outValid", 32'd0, {31'b0, outValid});
      compareField("reset", "branchTaken", 32'd0, {31'b0, branchTaken});
      compareField("reset", "result", 32'd0, result);
      compareField("reset", "newPc", 32'd0, newPc);
      havePrev = 1'b0;
    end else begin
      name     = havePrev ? testName(prevTest) : "reset";
      expValid = havePrev & prevValid;
      compareField(name, "outValid", {31'b0, expValid}, {31'b0, outValid});
      compareField(name, "branchTaken", {31'b0, expValid & prevExpect[0]}, {31'b0, branchTaken});
      if (expValid) begin
        compareField(name, "result", prevExpect[64:33], result);
        compareField(name, "newPc", prevExpect[32:1], newPc);
      end
      havePrev   = 1'b1; // Record this edge's slot for the next compare
      prevValid  = inValid;
      prevTest   = testId;
      prevExpect = expectExec(opcode, funct7, funct3, pc, op1, op2, imm);
    end
  end

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic                        clk,
  input  logic                        arstN,
  input  logic                        inValid,
  input  logic [6:0]                  opcode,
  input  logic [6:0]                  funct7,
  input  logic [2:0]                  funct3,
  input  logic [rvPkg::WORD_SIZE-1:0] pc,
  input  logic [rvPkg::WORD_SIZE-1:0] op1,
  input  logic [rvPkg::WORD_SIZE-1:0] op2,
  input  logic [rvPkg::WORD_SIZE-1:0] imm,
  output logic                        outValid,
  output logic [rvPkg::WORD_SIZE-1:0] result,
  output logic [rvPkg::WORD_SIZE-1:0] newPc,
  output logic                        branchTaken
);

  logic [rvPkg::WORD_SIZE-1:0] aluResult;
  logic [rvPkg::WORD_SIZE-1:0] target;
  logic                        condition;

  execIf ex ();

  assign ex.valid  = inValid;
  assign ex.opcode = rvPkg::opcodeE'(opcode); // Raw bits onto the opcode enum
  assign ex.funct7 = funct7;
  assign ex.funct3 = funct3;
  assign ex.pc     = pc;
  assign ex.op1    = op1;
  assign ex.op2    = op2;
  assign ex.imm    = imm;

  // ==============================
  // Blocks
  // ==============================

  alu uAlu (
    .ex        (ex.arith),
    .aluResult (aluResult)
  );

  branchUnit uBranchUnit (
    .ex        (ex.branch),
    .target    (target),
    .condition (condition)
  );

  execCommit uExecCommit (
    .clk         (clk),
    .arstN       (arstN),
    .ex          (ex.commit),
    .aluResult   (aluResult),
    .target      (target),
    .condition   (condition),
    .outValid    (outValid),
    .result      (result),
    .newPc       (newPc),
    .branchTaken (branchTaken)
  );

endmodule

// File: verilog/execCommit.sv
`timescale 1ns/1ps

module execCommit (
  input  logic                        clk,
  input  logic                        arstN,
  execIf.commit                       ex,
  input  logic [rvPkg::WORD_SIZE-1:0] aluResult,
  input  logic [rvPkg::WORD_SIZE-1:0] target,
  input  logic                        condition,
  output logic                        outValid,
  output logic [rvPkg::WORD_SIZE-1:0] result,
  output logic [rvPkg::WORD_SIZE-1:0] newPc,
  output logic                        branchTaken
);

  logic [rvPkg::WORD_SIZE-1:0] resultNext;
  logic                        takenNext;

  // ==============================
  // Selection
  // ==============================

  always_comb begin
    if (ex.opcode == rvPkg::OPCODE_AUIPC) begin
      resultNext = target; // pc plus immediate
    end else begin
      resultNext = aluResult;
    end
  end

  assign takenNext = condition & ex.valid; // Empty slots never redirect fetch

  // ==============================
  // Output register
  // ==============================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid    <= 1'b0;
      branchTaken <= 1'b0;
      result      <= '0;
      newPc       <= '0;
    end else begin
      outValid    <= ex.valid;
      branchTaken <= takenNext;
      result      <= resultNext; // Follows the data path even in bubbles
      newPc       <= target;
    end
  end

endmodule

// File: verilog/branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
  execIf.branch                       ex,
  output logic [rvPkg::WORD_SIZE-1:0] target,
  output logic                        condition
);

  logic opEqual;
  logic opBelow;

  assign target = ex.pc + ex.imm; // Branch, jump and AUIPC all use this sum

  // Operands are unsigned words, so these are unsigned compares
  assign opEqual = (ex.op1 == ex.op2);
  assign opBelow = (ex.op1 < ex.op2);

  // ==============================
  // Condition decode
  // ==============================

  always_comb begin
    condition = 1'b0;

    case (ex.opcode)
      rvPkg::OPCODE_BRANCH: begin
        case (ex.funct3)
          rvPkg::BEQ_FUNCT3: begin
            condition = opEqual;
          end
          rvPkg::BNE_FUNCT3: begin
            condition = !opEqual;
          end
          rvPkg::BLT_FUNCT3: begin
            condition = opBelow;
          end
          rvPkg::BGE_FUNCT3: begin
            condition = !opBelow; // At or above
          end
          default: begin
            condition = 1'b0; // Unsupported branch kinds never fire
          end
        endcase
      end

      rvPkg::OPCODE_JUMP: begin
        condition = 1'b1;
      end

      default: begin
        condition = 1'b0;
      end
    endcase
  end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
  execIf.arith                        ex,
  output logic [rvPkg::WORD_SIZE-1:0] aluResult
);

  logic [rvPkg::WORD_SIZE-1:0] aluAdd;
  logic [rvPkg::WORD_SIZE-1:0] aluSub;
  logic [rvPkg::WORD_SIZE-1:0] aluMul;
  logic [rvPkg::WORD_SIZE-1:0] addrSum;

  assign aluAdd  = ex.op1 + ex.op2;
  assign aluSub  = ex.op1 - ex.op2;
  assign aluMul  = ex.op1 * ex.op2; // Low word of the product
  assign addrSum = ex.op1 + ex.imm; // Shared by loads, stores and addi

  // ==============================
  // Result decode
  // ==============================

  always_comb begin
    aluResult = '0; // Unlisted combinations give zero

    case (ex.opcode)
      rvPkg::OPCODE_ALU: begin
        case (ex.funct7)
          rvPkg::SUB_FUNCT7: begin
            aluResult = aluSub;
          end
          rvPkg::MUL_FUNCT7: begin
            aluResult = aluMul;
          end
          rvPkg::ADD_OR_AND_FUNCT7: begin
            case (ex.funct3)
              rvPkg::ADD_FUNCT3: aluResult = aluAdd;
              rvPkg::OR_FUNCT3:  aluResult = ex.op1 | ex.op2;
              rvPkg::AND_FUNCT3: aluResult = ex.op1 & ex.op2;
              default:           aluResult = '0;
            endcase
          end
          default: begin
            aluResult = '0;
          end
        endcase
      end

      rvPkg::OPCODE_ALU_IMM: begin
        if (ex.funct3 == rvPkg::ADDI_FUNCT3) begin
          aluResult = addrSum;
        end
      end

      rvPkg::OPCODE_LOAD,
      rvPkg::OPCODE_STORE: begin
        aluResult = addrSum; // Effective address
      end

      rvPkg::OPCODE_BRANCH: begin
        aluResult = aluSub; // Difference of the compared operands
      end

      default: begin
        aluResult = '0; // Jumps and AUIPC commit no ALU value
      end
    endcase
  end

endmodule

// File: verilog/execIf.sv
`timescale 1ns/1ps

interface execIf;

  logic                        valid;  // Slot holds a real instruction
  rvPkg::opcodeE               opcode;
  logic [6:0]                  funct7;
  logic [2:0]                  funct3;
  logic [rvPkg::WORD_SIZE-1:0] pc;
  logic [rvPkg::WORD_SIZE-1:0] op1;
  logic [rvPkg::WORD_SIZE-1:0] op2;
  logic [rvPkg::WORD_SIZE-1:0] imm;

  // Data path view
  modport arith (input opcode, funct7, funct3, op1, op2, imm);

  // Target address and condition view
  modport branch (input opcode, funct3, pc, op1, op2, imm);

  // Result selection only needs the strobe and the class
  modport commit (input valid, opcode);

endinterface

// File: verilog/rvPkg.sv
package rvPkg;

  // ==============================
  // Widths
  // ==============================

  localparam int WORD_SIZE = 32; // Data and address width of the core

  // ==============================
  // Opcodes
  // ==============================

  // Instruction classes understood by the execute stage
  typedef enum logic [6:0] {
    OPCODE_ALU     = 7'b0110011, // Register-register arithmetic
    OPCODE_ALU_IMM = 7'b0010011, // Register-immediate arithmetic
    OPCODE_AUIPC   = 7'b0010111, // Add upper immediate to pc
    OPCODE_BRANCH  = 7'b1100011, // Conditional branches
    OPCODE_JUMP    = 7'b1101111, // Unconditional jump
    OPCODE_LOAD    = 7'b0000011, // Load address generation
    OPCODE_STORE   = 7'b0100011  // Store address generation
  } opcodeE;

  // ==============================
  // Function fields
  // ==============================

  // funct7 selects the operation family inside OPCODE_ALU
  localparam logic [6:0] ADD_OR_AND_FUNCT7 = 7'b0000000;
  localparam logic [6:0] SUB_FUNCT7        = 7'b0100000;
  localparam logic [6:0] MUL_FUNCT7        = 7'b0000001;

  // funct3 for register-register operations under funct7 zero
  localparam logic [2:0] ADD_FUNCT3 = 3'b000;
  localparam logic [2:0] OR_FUNCT3  = 3'b110;
  localparam logic [2:0] AND_FUNCT3 = 3'b111;

  // funct3 for register-immediate operations
  localparam logic [2:0] ADDI_FUNCT3 = 3'b000;

  // funct3 for conditional branches, all compares unsigned
  localparam logic [2:0] BEQ_FUNCT3 = 3'b000;
  localparam logic [2:0] BNE_FUNCT3 = 3'b001;
  localparam logic [2:0] BLT_FUNCT3 = 3'b100;
  localparam logic [2:0] BGE_FUNCT3 = 3'b101;

endpackage
